// File: include/sha_rig_macros.svh
// Timing macros for the debouncer, one-second tick and SHA round count
`ifndef SHA_RIG_MACROS_SVH
`define SHA_RIG_MACROS_SVH

// Scaled down so a run takes a few thousand clocks
`define DB_PRESS_CYCLES   20      // 240000 on the 48 MHz board for 5 ms of contact
`define DB_PULSE_CYCLES   100     // Board pulse window ends at 25 ms
`define DB_LONG_CYCLES    400     // About 2/3 s to a long hold on the board
`define DB_RELEASE_CYCLES 200     // 100 ms low before release on the board
`define SECOND_CYCLES     1000    // 48000000 on the board

// One compression round per clock
`define SHA_ROUNDS        64

`endif

// File: logic/button_debounce.sv
// Fire button synchronizer and press/long-hold debounce state machine
`timescale 1ns/1ps
`include "sha_rig_macros.svh"

module button_debounce (
	input  logic clk,
	input  logic reset,
	input  logic fire_button,   // Raw pad, asynchronous
	output logic press,         // One clock at start of pulse window
	output logic hold           // High while held past the long time
);

	typedef enum logic [2:0] {
		S_IDLE, S_WAIT_PRESS, S_PULSE, S_WAIT_LONG,
		S_LONG, S_WAIT_OFF, S_WAIT_LONG_OFF
	} db_state_t;

	localparam logic [25:0] PRESS_END   = 26'(`DB_PRESS_CYCLES);
	localparam logic [25:0] PULSE_END   = 26'(`DB_PULSE_CYCLES);
	localparam logic [25:0] LONG_END    = 26'(`DB_LONG_CYCLES);
	localparam logic [22:0] RELEASE_END = 23'(`DB_RELEASE_CYCLES);

	db_state_t   state;
	logic [2:0]  sync_q;       // Metastability chain
	logic        btn;
	logic        was_pulse;
	logic [25:0] press_cnt;    // Time since leaving idle
	logic [22:0] release_cnt;  // Time spent low

	assign btn = sync_q[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q    <= '0;
			state     <= S_IDLE;
			was_pulse <= 1'b0;
		end else begin
			sync_q    <= {sync_q[1:0], fire_button};
			was_pulse <= (state == S_PULSE);
			case (state)
				S_IDLE:          state <= btn ? S_WAIT_PRESS : S_IDLE;
				S_WAIT_PRESS:    state <= !btn ? S_IDLE :
				                          (press_cnt == PRESS_END) ? S_PULSE : S_WAIT_PRESS;
				S_PULSE:         state <= (press_cnt == PULSE_END) ? S_WAIT_LONG : S_PULSE;
				S_WAIT_LONG:     state <= !btn ? S_WAIT_OFF :
				                          (press_cnt == LONG_END) ? S_LONG : S_WAIT_LONG;
				S_LONG:          state <= !btn ? S_WAIT_LONG_OFF : S_LONG;
				S_WAIT_OFF:      state <= btn ? S_WAIT_LONG :
				                          (release_cnt == RELEASE_END) ? S_IDLE : S_WAIT_OFF;
				S_WAIT_LONG_OFF: state <= btn ? S_LONG :
				                          (release_cnt == RELEASE_END) ? S_IDLE : S_WAIT_LONG_OFF;
				default:         state <= S_IDLE;
			endcase
		end
	end

	// Press count saturates at the long mark
	always_ff @(posedge clk) begin
		if (reset) begin
			press_cnt   <= '0;
			release_cnt <= '0;
		end else begin
			if (state == S_IDLE)
				press_cnt <= '0;
			else if (press_cnt != LONG_END)
				press_cnt <= press_cnt + 26'd1;
			release_cnt <= (state == S_WAIT_OFF || state == S_WAIT_LONG_OFF) ? release_cnt + 23'd1 : '0;
		end
	end

	assign press = (state == S_PULSE) && !was_pulse;                 // Entry edge only
	assign hold  = (state == S_LONG) || (state == S_WAIT_LONG_OFF);

endmodule

// File: logic/hash_rate_meter.sv
// Total operation counter, one-second tick and per-second rate latch
`timescale 1ns/1ps
`include "sha_rig_macros.svh"

module hash_rate_meter
	import sha_rig_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      digest_valid,
	output op_count_t op_count,      // Since reset
	output rate_t     ops_per_sec    // Count from the last full second
);

	localparam int              SEC_W   = $clog2(`SECOND_CYCLES);
	localparam logic [SEC_W-1:0] SEC_END = SEC_W'(`SECOND_CYCLES - 1);

	logic [SEC_W-1:0] sec_cnt;
	logic             second_tick;
	rate_t            window_cnt;

	assign second_tick = (sec_cnt == SEC_END);

	always_ff @(posedge clk) begin
		if (reset) begin
			op_count    <= '0;
			sec_cnt     <= '0;
			window_cnt  <= '0;
			ops_per_sec <= '0;
		end else begin
			op_count <= digest_valid ? op_count + 48'd1 : op_count;
			sec_cnt  <= second_tick ? '0 : sec_cnt + 1'b1;
			if (second_tick) begin
				ops_per_sec <= window_cnt + 32'(digest_valid);  // Include a hit on the tick
				window_cnt  <= '0;
			end else begin
				window_cnt <= window_cnt + 32'(digest_valid);
			end
		end
	end

endmodule

// File: logic/hash_sequencer.sv
// Step counter that issues the two message blocks and the redo passes
`timescale 1ns/1ps

module hash_sequencer
	import sha_rig_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   press,        // Short press, one pass
	input  logic   hold,         // Long hold, keep redoing block 1
	output logic   block_load,
	output logic   redo,
	output logic   busy,
	output block_t block_data
);

	////////////////////////////////////////////////////////////////////////
	// Step map
	//   1    block 0 from the initial hash
	//   66   block 1 from the mid-state, redo
	//   131  digest out, then loop or idle
	////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] STEP_IDLE   = 8'd0;
	localparam logic [7:0] STEP_BLOCK0 = 8'd1;
	localparam logic [7:0] STEP_BLOCK1 = 8'd66;
	localparam logic [7:0] STEP_LAST   = 8'd131;

	logic [7:0] step;

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= STEP_IDLE;
		end else if (step == STEP_IDLE) begin
			if (press || hold)
				step <= STEP_BLOCK0;
		end else if (step == STEP_LAST) begin
			step <= hold ? STEP_BLOCK1 : STEP_IDLE;  // Redo pass keeps 66 clock spacing
		end else begin
			step <= step + 8'd1;
		end
	end

	// Core is idle at both issue steps
	assign block_load = (step == STEP_BLOCK0) || (step == STEP_BLOCK1);
	assign redo       = (step == STEP_BLOCK1);
	assign block_data = redo ? MSG_BLOCK1 : MSG_BLOCK0;
	assign busy       = (step != STEP_IDLE);

endmodule

// File: logic/sha256_core.sv
// Iterative SHA-256 compression, rolling message schedule and chaining mid-state
`timescale 1ns/1ps
`include "sha_rig_macros.svh"

module sha256_core
	import sha_rig_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    block_load,    // Taken only when idle
	input  logic    redo,          // Start from mid-state, report digest
	input  block_t  block_data,
	output digest_t digest,
	output logic    digest_valid
);

	localparam logic [6:0] LAST_ROUND = 7'(`SHA_ROUNDS);

	function automatic word_t rotr(input word_t x, input int n);
		rotr = (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t sig0(input word_t x);   // Schedule sigma0
		sig0 = rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t sig1(input word_t x);   // Schedule sigma1
		sig1 = rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	logic       active;
	logic       redo_q;
	logic [6:0] rnd;        // Next round to run
	logic       start, rounding, finishing;
	digest_t    work;       // a..h
	digest_t    mid;        // Hash after block 0
	block_t     sched;      // W[t]..W[t+15]
	digest_t    st_in, st_next, base, sum;
	block_t     sched_in, sched_next;
	word_t      k_t, w_t, s0, s1, ch, maj, t1, t2;

	assign start     = block_load && !active;
	assign rounding  = active && (rnd != LAST_ROUND);
	assign finishing = active && (rnd == LAST_ROUND);

	// Round 0 runs straight off the load, so a block is 65 clocks
	always_comb begin
		st_in    = start ? (redo ? mid : HASH_INIT) : work;
		sched_in = start ? block_data : sched;
		w_t      = sched_in[0];
		k_t      = ROUND_K[start ? 6'd0 : rnd[5:0]];

		s1  = rotr(st_in[4], 6) ^ rotr(st_in[4], 11) ^ rotr(st_in[4], 25);
		ch  = (st_in[4] & st_in[5]) ^ (~st_in[4] & st_in[6]);
		t1  = st_in[7] + s1 + ch + k_t + w_t;
		s0  = rotr(st_in[0], 2) ^ rotr(st_in[0], 13) ^ rotr(st_in[0], 22);
		maj = (st_in[0] & st_in[1]) ^ (st_in[0] & st_in[2]) ^ (st_in[1] & st_in[2]);
		t2  = s0 + maj;
		st_next = {t1 + t2, st_in[0], st_in[1], st_in[2],
		           st_in[3] + t1, st_in[4], st_in[5], st_in[6]};

		// W[t+16] enters at the bottom
		sched_next = {sched_in[1:15],
		              sig1(sched_in[14]) + sched_in[9] + sig0(sched_in[1]) + sched_in[0]};
	end

	// Final add against the state the block started from
	always_comb begin
		base = redo_q ? mid : HASH_INIT;
		for (int i = 0; i < 8; i++)
			sum[i] = base[i] + work[i];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active       <= 1'b0;
			redo_q       <= 1'b0;
			rnd          <= '0;
			digest       <= '0;
			digest_valid <= 1'b0;
		end else begin
			digest_valid <= 1'b0;
			if (start) begin
				active <= 1'b1;
				redo_q <= redo;
				rnd    <= 7'd1;
			end else if (rounding) begin
				rnd <= rnd + 7'd1;
			end else if (finishing) begin
				active <= 1'b0;
				if (redo_q) begin
					digest       <= sum;
					digest_valid <= 1'b1;
				end
			end
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (start || rounding) begin
			work  <= st_next;
			sched <= sched_next;
		end
		if (finishing && !redo_q)
			mid <= sum;   // Kept for every redo pass
	end

endmodule

// File: logic/sha_hash_rig.sv
// Top level, debouncer and sequencer feeding the SHA-256 core, rate meter on its output
`timescale 1ns/1ps

module sha_hash_rig
	import sha_rig_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      fire_button,
	output digest_t   digest,
	output logic      digest_valid,
	output op_count_t op_count,
	output rate_t     ops_per_sec,
	output logic      busy
);

	logic   press;
	logic   hold;
	logic   block_load;
	logic   redo;
	block_t block_data;

	button_debounce _debounce (
		.clk( clk ), .reset( reset ),
		.fire_button( fire_button ),
		.press( press ), .hold( hold )
	);

	hash_sequencer _sequencer (
		.clk( clk ), .reset( reset ),
		.press( press ), .hold( hold ),
		.block_load( block_load ), .redo( redo ), .busy( busy ),
		.block_data( block_data )
	);

	sha256_core _core (
		.clk( clk ), .reset( reset ),
		.block_load( block_load ), .redo( redo ), .block_data( block_data ),
		.digest( digest ), .digest_valid( digest_valid )
	);

	hash_rate_meter _rate (
		.clk( clk ), .reset( reset ),
		.digest_valid( digest_valid ),
		.op_count( op_count ), .ops_per_sec( ops_per_sec )
	);

endmodule

// File: logic/sha_rig_pkg.sv
// SHA word, block and digest types, round constants, initial hash, test message blocks
package sha_rig_pkg;

	typedef logic [31:0]   word_t;
	typedef word_t [0:15]  block_t;    // Word 0 first, as in FIPS 180-4
	typedef word_t [0:7]   digest_t;   // H0 in the top word
	typedef logic [47:0]   op_count_t;
	typedef word_t         rate_t;

	// Round constants K0..K63
	localparam word_t [0:63] ROUND_K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// H(0) from the fractional parts of the first eight prime square roots
	localparam digest_t HASH_INIT = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq" plus the 1 bit
	localparam block_t MSG_BLOCK0 = {
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
	};

	// Zero fill, then message length of 448 bits
	localparam block_t MSG_BLOCK1 = {
		32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'h000001c0
	};

endpackage

// File: sim/clock_gen.sv
// Testbench clock, 4 ns period, and a two-cycle synchronous reset
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;   // Released on an edge, like the board reset
	end

	always #2 clk = ~clk;   // 250 MHz

endmodule

// File: sim/hash_trace.txt
# command and values per line: vector H0..H7, reset_state, press N, release N, wait_idle LIMIT
# digests MIN MAX (pulses since last digests line), count N, count_tracks, rate LO HI
vector 248d6a61 d20638b8 e5c02693 0c3e6039 a33ce459 64ff2167 f6ecedd4 19db06c1
reset_state
press 150
release 300
wait_idle 400
digests 1 1
count 1
press 10
release 400
digests 0 0
count 1
press 1500
release 300
wait_idle 400
digests 10 30
count_tracks
press 2800
rate 15 16
release 300
wait_idle 400
digests 30 50
count_tracks

// File: sim/tb_sha_hash_rig.sv
// Trace-driven testbench for the SHA-256 hash rig with digest monitor and error counts
`timescale 1ns/1ps

module tb_sha_hash_rig
	import sha_rig_pkg::*;
();

	logic      clk;
	logic      reset;
	logic      fire_button;
	digest_t   digest;
	logic      digest_valid;
	op_count_t op_count;
	rate_t     ops_per_sec;
	logic      busy;

	int        value_errors;
	int        timeout_errors;
	int        other_errors;
	bit        timed_out;
	bit        have_vector;
	digest_t   expect_digest;   // Loaded from the trace
	int        total_pulses;    // Every digest_valid seen since reset
	int        window_pulses;   // Since the last digests line

	clock_gen clocks (
		.clk( clk ), .reset( reset )
	);

	sha_hash_rig UUT (
		.clk( clk ), .reset( reset ),
		.fire_button( fire_button ),
		.digest( digest ), .digest_valid( digest_valid ),
		.op_count( op_count ), .ops_per_sec( ops_per_sec ),
		.busy( busy )
	);

	//////////////////////////////////////////////////////////////////////
	// Digest monitor
	//////////////////////////////////////////////////////////////////////

	// Sampled on the edge, before the DUT's outputs move
	always @(posedge clk) begin
		if (!reset && digest_valid) begin
			total_pulses  = total_pulses + 1;
			window_pulses = window_pulses + 1;
			if (!have_vector) begin
				other_errors++;
				$display("digest_valid at %0t before any expected vector was loaded", $time);
			end else if (digest !== expect_digest) begin
				value_errors++;
				$display("FAILED t=%0t digest expected %h got %h", $time, expect_digest, digest);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and check tasks
	//////////////////////////////////////////////////////////////////////

	// Button level held for a fixed number of clocks
	task automatic drive_button(input logic level, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			fire_button <= level;
		end
	endtask

	task automatic wait_idle(input int limit);
		int waited;
		waited = 0;
		@(negedge clk);
		while (busy !== 1'b0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (busy !== 1'b0) begin
			timeout_errors++;
			timed_out = 1'b1;
			$display("Timeout at %0t, busy still high after %0d cycles", $time, limit);
		end
	endtask

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic verify_reset_outputs();
		@(negedge clk);
		compare_value("digest_valid", 0, digest_valid);
		compare_value("busy", 0, busy);
		compare_value("op_count", 0, op_count);
		compare_value("ops_per_sec", 0, ops_per_sec);
		if (digest !== '0) begin
			value_errors++;
			$display("FAILED t=%0t digest expected %h got %h", $time, 256'h0, digest);
		end
	endtask

	task automatic range_check(input string name, input int lo, input int hi, input int actual);
		if (actual < lo || actual > hi) begin
			value_errors++;
			$display("FAILED t=%0t %s expected %0d..%0d got %0d", $time, name, lo, hi, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Trace reader
	//////////////////////////////////////////////////////////////////////

	initial begin
		int                fd;
		int                fields;
		int                n1, n2;
		int                waited;
		word_t             vec [0:7];
		reg [8*200-1:0]    line;
		reg [8*16-1:0]     cmd;

		fire_button    = 1'b0;
		value_errors   = 0;
		timeout_errors = 0;
		other_errors   = 0;
		timed_out      = 1'b0;
		have_vector    = 1'b0;
		total_pulses   = 0;
		window_pulses  = 0;

		waited = 0;
		while (reset !== 1'b0 && waited < 20) begin   // Reset release
			@(negedge clk);
			waited++;
		end
		if (reset !== 1'b0) begin
			timeout_errors++;
			timed_out = 1'b1;
			$display("Timeout, reset never released");
		end

		fd = $fopen("sim/hash_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the trace file sim/hash_trace.txt");
		end

		while (fd != 0 && !timed_out && !$feof(fd)) begin
			line = '0;
			cmd  = '0;
			fields = $fgets(line, fd);
			fields = $sscanf(line, "%s", cmd);
			if (fields < 1 || cmd == "#")
				continue;   // Blank or comment line
			case (cmd)
				"vector": begin
					fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", cmd,
					                 vec[0], vec[1], vec[2], vec[3],
					                 vec[4], vec[5], vec[6], vec[7]);
					for (int i = 0; i < 8; i++)
						expect_digest[i] = vec[i];   // H0 first
					have_vector = 1'b1;
				end
				"reset_state": verify_reset_outputs();
				"press": begin
					fields = $sscanf(line, "%s %d", cmd, n1);
					drive_button(1'b1, n1);
				end
				"release": begin
					fields = $sscanf(line, "%s %d", cmd, n1);
					drive_button(1'b0, n1);
				end
				"wait_idle": begin
					fields = $sscanf(line, "%s %d", cmd, n1);
					wait_idle(n1);
				end
				"digests": begin
					fields = $sscanf(line, "%s %d %d", cmd, n1, n2);
					@(negedge clk);
					range_check("digest_valid pulses", n1, n2, window_pulses);
					window_pulses = 0;
				end
				"count": begin
					fields = $sscanf(line, "%s %d", cmd, n1);
					@(negedge clk);
					compare_value("op_count", n1, op_count);
				end
				"count_tracks": begin
					@(negedge clk);
					compare_value("op_count", total_pulses, op_count);   // One per pulse seen
				end
				"rate": begin
					fields = $sscanf(line, "%s %d %d", cmd, n1, n2);
					@(negedge clk);
					range_check("ops_per_sec", n1, n2, ops_per_sec);
				end
				default: begin
					other_errors++;
					$display("Unknown trace command in line: %0s", line);
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);

		$display("Errors: %0d value, %0d timeout, %0d other; %0d digests seen",
		         value_errors, timeout_errors, other_errors, total_pulses);
		if (value_errors == 0 && timeout_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+include
logic/sha_rig_pkg.sv
logic/button_debounce.sv
logic/hash_sequencer.sv
logic/sha256_core.sv
logic/hash_rate_meter.sv
logic/sha_hash_rig.sv
sim/clock_gen.sv
sim/tb_sha_hash_rig.sv
